/* source/sv39_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Sv39 widths and PTE bit positions. The A bit (6) is kept in PTEs but never read.
// ~~~~~~~~~~~~~~~~~~~~

package sv39_pkg;

  // Physical page number and address widths
  localparam int unsigned PPN_LEN         = 44;
  localparam int unsigned PADDR_LEN       = 56;
  localparam int unsigned PAGE_OFFSET_LEN = 12;

  // Virtual page number made of three 9-bit parts
  localparam int unsigned VPN_PART_LEN    = 9;
  localparam int unsigned PT_LEVELS       = 3;
  localparam int unsigned VPN_LEN         = PT_LEVELS * VPN_PART_LEN;

  // PTE layout
  localparam int unsigned PTE_LEN         = 64;
  localparam int unsigned PTE_V_BIT       = 0;
  localparam int unsigned PTE_R_BIT       = 1;
  localparam int unsigned PTE_W_BIT       = 2;
  localparam int unsigned PTE_X_BIT       = 3;
  localparam int unsigned PTE_U_BIT       = 4;
  localparam int unsigned PTE_G_BIT       = 5;
  localparam int unsigned PTE_D_BIT       = 7;
  localparam int unsigned PTE_PPN_LSB     = 10;
  localparam int unsigned PTE_PPN_MSB     = PTE_PPN_LSB + PPN_LEN - 1;

  typedef logic [PPN_LEN-1:0]   ppn_t;
  // Part 2 in the top bits, part 0 in the bottom bits
  typedef logic [VPN_LEN-1:0]   vpn_t;
  typedef logic [PTE_LEN-1:0]   pte_t;
  typedef logic [PADDR_LEN-1:0] paddr_t;

endpackage

/* source/ptw_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Walker-side encodings. Level values equal the Sv39 level index.
// ~~~~~~~~~~~~~~~~~~~~

package ptw_pkg;

  // Level of the table being read
  typedef enum logic [1:0] {
    Root = 2'd2,
    Mid  = 2'd1,
    Leaf = 2'd0
  } pte_level_e;

  // Size of the translated page
  typedef enum logic [1:0] {
    GibiPage,
    MebiPage,
    KibiPage
  } page_type_e;

  // Walk outcome
  typedef enum logic {
    NoException,
    PageFault
  } exception_e;

  // W in bit 2, R in bit 1, X in bit 0
  typedef logic [2:0] wrx_t;

endpackage

/* source/pte_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Pure logic. Exactly one of leaf, next or fault holds for any PTE.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pte_checker (
  input  sv39_pkg::pte_t       pte_i,
  input  ptw_pkg::pte_level_e  level_i,
  output logic                 leaf_o,
  output logic                 next_o,
  output ptw_pkg::exception_e  exception_o
);

  import sv39_pkg::*;
  import ptw_pkg::*;

  logic v, r, w, x;
  logic is_leaf_type;
  logic misaligned;
  logic fault;

  assign v = pte_i[PTE_V_BIT];
  assign r = pte_i[PTE_R_BIT];
  assign w = pte_i[PTE_W_BIT];
  assign x = pte_i[PTE_X_BIT];

  // R or X set marks a leaf
  assign is_leaf_type = r | x;

  // Superpage leaves need the lower PPN parts cleared
  always_comb begin
    misaligned = 1'b0;
    if (is_leaf_type) begin
      case (level_i)
        Root:    misaligned = |pte_i[PTE_PPN_LSB +: 2*VPN_PART_LEN];
        Mid:     misaligned = |pte_i[PTE_PPN_LSB +: VPN_PART_LEN];
        default: misaligned = 1'b0;
      endcase
    end
  end

  // Invalid, write-only, pointer at the last level, or misaligned superpage
  assign fault = !v || (w && !r) || (!is_leaf_type && level_i == Leaf) || misaligned;

  assign leaf_o      = !fault && is_leaf_type;
  assign next_o      = !fault && !is_leaf_type;
  assign exception_o = fault ? PageFault : NoException;

  // The walker relies on a single outcome per PTE
  leaf_next_excl_a : assert final (!(leaf_o && next_o));

endmodule

/* source/ptw.sv */
// ~~~~~~~~~~~~~~~~~~~~
// No walk cache and no A/D update. Every walk starts at the CSR root PPN.
// Fault answers carry the fields of the faulting PTE.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ptw (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  sv39_pkg::ppn_t       csr_root_ppn_i,
  // TLB request
  input  logic                 req_valid_i,
  input  sv39_pkg::vpn_t       req_vpn_i,
  output logic                 req_rdy_o,
  // TLB answer
  output logic                 ans_valid_o,
  input  logic                 ans_rdy_i,
  output sv39_pkg::ppn_t       ans_ppn_o,
  output ptw_pkg::page_type_e  ans_page_type_o,
  output ptw_pkg::exception_e  ans_exception_o,
  output ptw_pkg::wrx_t        ans_wrx_o,
  output logic                 ans_d_o,
  output logic                 ans_g_o,
  output logic                 ans_u_o,
  // PTE read port
  output logic                 rd_req_o,
  output sv39_pkg::paddr_t     rd_paddr_o,
  input  logic                 rd_gnt_i,
  input  logic                 rd_valid_i,
  input  sv39_pkg::pte_t       rd_pte_i
);

  import sv39_pkg::*;
  import ptw_pkg::*;

  typedef enum logic [2:0] {Idle, Issue, WaitData, Check, Answer} state_e;

  state_e                     state_q, state_d;
  pte_level_e                 level_q;
  vpn_t                       vpn_q;
  ppn_t                       table_ppn_q;
  pte_t                       pte_q;
  logic [VPN_PART_LEN-1:0]    vpn_part;
  logic [PAGE_OFFSET_LEN-1:0] pte_offset;
  logic                       chk_leaf, chk_next;
  exception_e                 chk_exception;
  logic                       accept;
  logic                       walk_done;
  page_type_e                 page_type_d;

  // Answer register
  ppn_t                       ans_ppn_q;
  page_type_e                 ans_page_type_q;
  exception_e                 ans_exception_q;
  wrx_t                       ans_wrx_q;
  logic                       ans_d_q, ans_g_q, ans_u_q;

  // No new walk on a flush cycle
  assign req_rdy_o = (state_q == Idle) && !flush_i;
  assign accept    = req_valid_i && req_rdy_o;
  // Leaf or fault ends the walk
  assign walk_done = (state_q == Check) && (chk_leaf || chk_exception == PageFault);

  // Control FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle:     if (accept) state_d = Issue;
      Issue:    if (rd_gnt_i) state_d = WaitData;
      WaitData: if (rd_valid_i) state_d = Check;
      Check:    state_d = chk_next ? Issue : Answer;
      Answer:   if (ans_rdy_i) state_d = Idle;
      default:  state_d = Idle;
    endcase
    if (flush_i) begin
      state_d = Idle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Level sequencer, Root down to Leaf
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      level_q <= Root;
    end else if (flush_i || accept) begin
      level_q <= Root;
    end else if (state_q == Check && chk_next) begin
      case (level_q)
        Root:    level_q <= Mid;
        Mid:     level_q <= Leaf;
        default: level_q <= Leaf;
      endcase
    end
  end

  // VPN part picked by the current level
  always_comb begin
    case (level_q)
      Root:    vpn_part = vpn_q[2*VPN_PART_LEN +: VPN_PART_LEN];
      Mid:     vpn_part = vpn_q[VPN_PART_LEN +: VPN_PART_LEN];
      default: vpn_part = vpn_q[0 +: VPN_PART_LEN];
    endcase
  end

  // PTE address: table base, index, 8-byte entry
  assign pte_offset = {vpn_part, 3'b000};
  assign rd_paddr_o = {table_ppn_q, pte_offset};
  assign rd_req_o   = (state_q == Issue);

  pte_checker pte_checker_inst (
    .pte_i       (pte_q),
    .level_i     (level_q),
    .leaf_o      (chk_leaf),
    .next_o      (chk_next),
    .exception_o (chk_exception)
  );

  always_comb begin
    case (level_q)
      Root:    page_type_d = GibiPage;
      Mid:     page_type_d = MebiPage;
      default: page_type_d = KibiPage;
    endcase
  end

  // Walk datapath and answer register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vpn_q           <= '0;
      table_ppn_q     <= '0;
      pte_q           <= '0;
      ans_ppn_q       <= '0;
      ans_page_type_q <= KibiPage;
      ans_exception_q <= NoException;
      ans_wrx_q       <= '0;
      ans_d_q         <= 1'b0;
      ans_g_q         <= 1'b0;
      ans_u_q         <= 1'b0;
    end else if (flush_i) begin
      vpn_q           <= '0;
      table_ppn_q     <= '0;
      pte_q           <= '0;
      ans_ppn_q       <= '0;
      ans_page_type_q <= KibiPage;
      ans_exception_q <= NoException;
      ans_wrx_q       <= '0;
      ans_d_q         <= 1'b0;
      ans_g_q         <= 1'b0;
      ans_u_q         <= 1'b0;
    end else begin
      if (accept) begin
        vpn_q       <= req_vpn_i;
        table_ppn_q <= csr_root_ppn_i;
      end
      if (state_q == WaitData && rd_valid_i) begin
        pte_q <= rd_pte_i;
      end
      // Pointer PTE becomes the next table base
      if (state_q == Check && chk_next) begin
        table_ppn_q <= pte_q[PTE_PPN_MSB:PTE_PPN_LSB];
      end
      if (walk_done) begin
        ans_ppn_q       <= pte_q[PTE_PPN_MSB:PTE_PPN_LSB];
        ans_page_type_q <= page_type_d;
        ans_exception_q <= chk_exception;
        ans_wrx_q       <= {pte_q[PTE_W_BIT], pte_q[PTE_R_BIT], pte_q[PTE_X_BIT]};
        ans_d_q         <= pte_q[PTE_D_BIT];
        ans_g_q         <= pte_q[PTE_G_BIT];
        ans_u_q         <= pte_q[PTE_U_BIT];
      end
    end
  end

  assign ans_valid_o     = (state_q == Answer);
  assign ans_ppn_o       = ans_ppn_q;
  assign ans_page_type_o = ans_page_type_q;
  assign ans_exception_o = ans_exception_q;
  assign ans_wrx_o       = ans_wrx_q;
  assign ans_d_o         = ans_d_q;
  assign ans_g_o         = ans_g_q;
  assign ans_u_o         = ans_u_q;

  // Request and address held until granted
  paddr_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req_o && !rd_gnt_i && !flush_i |=> rd_req_o && $stable(rd_paddr_o));

  // Read data only for a walk waiting on it, or left over from a flushed one
  rd_valid_state_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_valid_i |-> (state_q == WaitData) || $past(flush_i));

endmodule

/* source/pt_mem_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Two requesters, one grant per cycle. Read data is valid one cycle after grant.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pt_mem_arbiter #(
  parameter int unsigned MEM_AW = 12
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic [1:0]        req_i,
  input  sv39_pkg::paddr_t  paddr0_i,
  input  sv39_pkg::paddr_t  paddr1_i,
  output logic [1:0]        gnt_o,
  output logic [1:0]        rvalid_o,
  output sv39_pkg::pte_t    rdata_o,
  output logic              mem_re_o,
  output logic [MEM_AW-1:0] mem_raddr_o,
  input  sv39_pkg::pte_t    mem_rdata_i
);

  import sv39_pkg::*;

  // High when walker 1 wins a tie
  logic   prio_q;
  // Read in flight and its owner
  logic   valid_q;
  logic   owner_q;
  paddr_t sel_paddr;

  always_comb begin
    if (req_i[0] && req_i[1]) begin
      gnt_o = prio_q ? 2'b10 : 2'b01;
    end else begin
      gnt_o = req_i;
    end
  end

  assign sel_paddr   = gnt_o[1] ? paddr1_i : paddr0_i;
  // Word index of a 64-bit PTE
  assign mem_raddr_o = sel_paddr[MEM_AW+2:3];
  assign mem_re_o    = |gnt_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q  <= 1'b0;
      valid_q <= 1'b0;
      owner_q <= 1'b0;
    end else begin
      valid_q <= |gnt_o;
      if (|gnt_o) begin
        // Last winner drops to low priority
        prio_q  <= gnt_o[0];
        owner_q <= gnt_o[1];
      end
    end
  end

  // Data shared, valid only to the owner
  assign rvalid_o = {valid_q && owner_q, valid_q && !owner_q};
  assign rdata_o  = mem_rdata_i;

  gnt_onehot_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(gnt_o));

endmodule

/* source/pt_memory.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Read during a write to the same word returns the old PTE.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pt_memory #(
  parameter int unsigned MEM_AW = 12
) (
  input  logic              clk_i,
  input  logic              re_i,
  input  logic [MEM_AW-1:0] raddr_i,
  output sv39_pkg::pte_t    rdata_o,
  input  logic              we_i,
  input  logic [MEM_AW-1:0] waddr_i,
  input  sv39_pkg::pte_t    wdata_i
);

  import sv39_pkg::*;

  pte_t mem_q [2**MEM_AW];
  pte_t rdata_q;

  // Table load port
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // One-cycle read, output held between reads
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_q <= mem_q[raddr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* source/mmu_walk_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Walker 0 serves the ITLB, walker 1 the DTLB. Tables fill through the mem_ port.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mmu_walk_top #(
  parameter int unsigned MEM_AW = 12
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  sv39_pkg::ppn_t       csr_root_ppn_i,
  // ITLB side
  input  logic                 itlb_req_valid_i,
  input  sv39_pkg::vpn_t       itlb_req_vpn_i,
  output logic                 itlb_req_rdy_o,
  output logic                 itlb_ans_valid_o,
  input  logic                 itlb_ans_rdy_i,
  output sv39_pkg::ppn_t       itlb_ans_ppn_o,
  output ptw_pkg::page_type_e  itlb_ans_page_type_o,
  output ptw_pkg::exception_e  itlb_ans_exception_o,
  output ptw_pkg::wrx_t        itlb_ans_wrx_o,
  output logic                 itlb_ans_d_o,
  output logic                 itlb_ans_g_o,
  output logic                 itlb_ans_u_o,
  // DTLB side
  input  logic                 dtlb_req_valid_i,
  input  sv39_pkg::vpn_t       dtlb_req_vpn_i,
  output logic                 dtlb_req_rdy_o,
  output logic                 dtlb_ans_valid_o,
  input  logic                 dtlb_ans_rdy_i,
  output sv39_pkg::ppn_t       dtlb_ans_ppn_o,
  output ptw_pkg::page_type_e  dtlb_ans_page_type_o,
  output ptw_pkg::exception_e  dtlb_ans_exception_o,
  output ptw_pkg::wrx_t        dtlb_ans_wrx_o,
  output logic                 dtlb_ans_d_o,
  output logic                 dtlb_ans_g_o,
  output logic                 dtlb_ans_u_o,
  // Page table load port
  input  logic                 mem_we_i,
  input  logic [MEM_AW-1:0]    mem_waddr_i,
  input  sv39_pkg::pte_t       mem_wdata_i
);

  import sv39_pkg::*;

  logic [1:0]        rd_req;
  logic [1:0]        rd_gnt;
  logic [1:0]        rd_valid;
  pte_t              rd_pte;
  paddr_t            itlb_paddr;
  paddr_t            dtlb_paddr;
  logic              mem_re;
  logic [MEM_AW-1:0] mem_raddr;
  pte_t              mem_rdata;

  ptw itlb_ptw (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .csr_root_ppn_i  (csr_root_ppn_i),
    .req_valid_i     (itlb_req_valid_i),
    .req_vpn_i       (itlb_req_vpn_i),
    .req_rdy_o       (itlb_req_rdy_o),
    .ans_valid_o     (itlb_ans_valid_o),
    .ans_rdy_i       (itlb_ans_rdy_i),
    .ans_ppn_o       (itlb_ans_ppn_o),
    .ans_page_type_o (itlb_ans_page_type_o),
    .ans_exception_o (itlb_ans_exception_o),
    .ans_wrx_o       (itlb_ans_wrx_o),
    .ans_d_o         (itlb_ans_d_o),
    .ans_g_o         (itlb_ans_g_o),
    .ans_u_o         (itlb_ans_u_o),
    .rd_req_o        (rd_req[0]),
    .rd_paddr_o      (itlb_paddr),
    .rd_gnt_i        (rd_gnt[0]),
    .rd_valid_i      (rd_valid[0]),
    .rd_pte_i        (rd_pte)
  );

  ptw dtlb_ptw (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .csr_root_ppn_i  (csr_root_ppn_i),
    .req_valid_i     (dtlb_req_valid_i),
    .req_vpn_i       (dtlb_req_vpn_i),
    .req_rdy_o       (dtlb_req_rdy_o),
    .ans_valid_o     (dtlb_ans_valid_o),
    .ans_rdy_i       (dtlb_ans_rdy_i),
    .ans_ppn_o       (dtlb_ans_ppn_o),
    .ans_page_type_o (dtlb_ans_page_type_o),
    .ans_exception_o (dtlb_ans_exception_o),
    .ans_wrx_o       (dtlb_ans_wrx_o),
    .ans_d_o         (dtlb_ans_d_o),
    .ans_g_o         (dtlb_ans_g_o),
    .ans_u_o         (dtlb_ans_u_o),
    .rd_req_o        (rd_req[1]),
    .rd_paddr_o      (dtlb_paddr),
    .rd_gnt_i        (rd_gnt[1]),
    .rd_valid_i      (rd_valid[1]),
    .rd_pte_i        (rd_pte)
  );

  pt_mem_arbiter #(
    .MEM_AW (MEM_AW)
  ) pt_mem_arbiter_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (rd_req),
    .paddr0_i    (itlb_paddr),
    .paddr1_i    (dtlb_paddr),
    .gnt_o       (rd_gnt),
    .rvalid_o    (rd_valid),
    .rdata_o     (rd_pte),
    .mem_re_o    (mem_re),
    .mem_raddr_o (mem_raddr),
    .mem_rdata_i (mem_rdata)
  );

  pt_memory #(
    .MEM_AW (MEM_AW)
  ) pt_memory_inst (
    .clk_i   (clk_i),
    .re_i    (mem_re),
    .raddr_i (mem_raddr),
    .rdata_o (mem_rdata),
    .we_i    (mem_we_i),
    .waddr_i (mem_waddr_i),
    .wdata_i (mem_wdata_i)
  );

endmodule

/* testbench/walk_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~
// One instance per TLB port. Expected answers are compared in request order.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module walk_checker #(
  parameter string PORT_NAME = "itlb"
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        ans_valid_i,
  input  logic        ans_rdy_i,
  // {ppn, page type, exception, wrx, d, g, u}
  input  logic [52:0] ans_i
);

  typedef logic [52:0] ans_t;

  string name_q [$];
  ans_t  exp_q [$];
  // Answer seen last cycle while it waited for ready
  ans_t  held_q;
  logic  held_valid_q;
  int    error_count = 0;

  function automatic void expect_answer(input string name, input ans_t exp);
    name_q.push_back(name);
    exp_q.push_back(exp);
  endfunction

  function automatic int pending();
    return exp_q.size();
  endfunction

  // Readable form of an answer vector
  function automatic string show(input ans_t a);
    return $sformatf("ppn=%h type=%0d exc=%0d wrx=%b dgu=%b",
                     a[52:9], a[8:7], a[6], a[5:3], a[2:0]);
  endfunction

  function automatic string current_name();
    return (name_q.size() != 0) ? name_q[0] : PORT_NAME;
  endfunction

  always @(posedge clk_i) begin
    string name;
    ans_t  exp;
    if (!rst_ni) begin
      held_valid_q <= 1'b0;
    end else begin
      // Stalled answer must keep its values and its valid
      if (held_valid_q && !ans_valid_i) begin
        $display("%s: answer valid dropped before ready was seen", current_name());
        error_count++;
      end else if (held_valid_q && ans_i !== held_q) begin
        $display("MISMATCH %s held answer changed, expected %s, actual %s",
                 current_name(), show(held_q), show(ans_i));
        error_count++;
      end
      held_valid_q <= ans_valid_i && !ans_rdy_i;
      held_q       <= ans_i;
      // Handshake pops the oldest expectation
      if (ans_valid_i && ans_rdy_i) begin
        if (exp_q.size() == 0) begin
          $display("%s: an answer arrived with no request waiting for it", PORT_NAME);
          error_count++;
        end else begin
          name = name_q.pop_front();
          exp  = exp_q.pop_front();
          if (ans_i !== exp) begin
            $display("MISMATCH %s expected %s, actual %s", name, show(exp), show(ans_i));
            error_count++;
          end
        end
      end
    end
  end

endmodule

/* testbench/tb_mmu_walk.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Whole PTE memory is filled before the tests, so every random walk reads defined data.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_mmu_walk;

  import sv39_pkg::*;
  import ptw_pkg::*;

  typedef logic [52:0] ans_t;

  localparam int unsigned MEM_AW      = 12;
  localparam int unsigned MEM_WORDS   = 2**MEM_AW;
  localparam int unsigned SEED        = 60591;
  // 9 directed, 30 random, 12 stalled, 2 around the flush
  localparam int unsigned N_REQ       = 53;
  localparam int unsigned CYCLE_LIMIT = MEM_WORDS + 16 + 40 * N_REQ + 200;
  localparam ppn_t        ROOT_PPN    = 44'd1;
  localparam ppn_t        MID_PPN     = 44'd2;
  localparam ppn_t        LEAF_PPN    = 44'd3;
  // PTE flag bits
  localparam logic [7:0]  FLAG_V = 8'h01;
  localparam logic [7:0]  FLAG_R = 8'h02;
  localparam logic [7:0]  FLAG_W = 8'h04;
  localparam logic [7:0]  FLAG_X = 8'h08;
  localparam logic [7:0]  FLAG_U = 8'h10;
  localparam logic [7:0]  FLAG_G = 8'h20;
  localparam logic [7:0]  FLAG_A = 8'h40;
  localparam logic [7:0]  FLAG_D = 8'h80;

  logic clk_i;
  logic rst_ni;
  logic flush_i;
  ppn_t csr_root_ppn_i;
  logic itlb_req_valid_i, dtlb_req_valid_i;
  vpn_t itlb_req_vpn_i, dtlb_req_vpn_i;
  logic itlb_req_rdy_o, dtlb_req_rdy_o;
  logic itlb_ans_valid_o, dtlb_ans_valid_o;
  logic itlb_ans_rdy_i, dtlb_ans_rdy_i;
  ppn_t itlb_ans_ppn_o, dtlb_ans_ppn_o;
  page_type_e itlb_ans_page_type_o, dtlb_ans_page_type_o;
  exception_e itlb_ans_exception_o, dtlb_ans_exception_o;
  wrx_t itlb_ans_wrx_o, dtlb_ans_wrx_o;
  logic itlb_ans_d_o, itlb_ans_g_o, itlb_ans_u_o;
  logic dtlb_ans_d_o, dtlb_ans_g_o, dtlb_ans_u_o;
  logic mem_we_i;
  logic [MEM_AW-1:0] mem_waddr_i;
  pte_t mem_wdata_i;

  ans_t itlb_ans, dtlb_ans;
  // Copy of what the load port wrote
  pte_t mirror [MEM_WORDS];
  logic stall_dtlb = 1'b0;
  int   other_errors = 0;
  int   cycle_count = 0;

  mmu_walk_top #(
    .MEM_AW (MEM_AW)
  ) mmu_walk_top_inst (
    .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush_i), .csr_root_ppn_i (csr_root_ppn_i),
    .itlb_req_valid_i (itlb_req_valid_i), .itlb_req_vpn_i (itlb_req_vpn_i),
    .itlb_req_rdy_o (itlb_req_rdy_o), .itlb_ans_valid_o (itlb_ans_valid_o),
    .itlb_ans_rdy_i (itlb_ans_rdy_i), .itlb_ans_ppn_o (itlb_ans_ppn_o),
    .itlb_ans_page_type_o (itlb_ans_page_type_o), .itlb_ans_exception_o (itlb_ans_exception_o),
    .itlb_ans_wrx_o (itlb_ans_wrx_o), .itlb_ans_d_o (itlb_ans_d_o),
    .itlb_ans_g_o (itlb_ans_g_o), .itlb_ans_u_o (itlb_ans_u_o),
    .dtlb_req_valid_i (dtlb_req_valid_i), .dtlb_req_vpn_i (dtlb_req_vpn_i),
    .dtlb_req_rdy_o (dtlb_req_rdy_o), .dtlb_ans_valid_o (dtlb_ans_valid_o),
    .dtlb_ans_rdy_i (dtlb_ans_rdy_i), .dtlb_ans_ppn_o (dtlb_ans_ppn_o),
    .dtlb_ans_page_type_o (dtlb_ans_page_type_o), .dtlb_ans_exception_o (dtlb_ans_exception_o),
    .dtlb_ans_wrx_o (dtlb_ans_wrx_o), .dtlb_ans_d_o (dtlb_ans_d_o),
    .dtlb_ans_g_o (dtlb_ans_g_o), .dtlb_ans_u_o (dtlb_ans_u_o),
    .mem_we_i (mem_we_i), .mem_waddr_i (mem_waddr_i), .mem_wdata_i (mem_wdata_i)
  );

  assign itlb_ans = {itlb_ans_ppn_o, itlb_ans_page_type_o, itlb_ans_exception_o,
                     itlb_ans_wrx_o, itlb_ans_d_o, itlb_ans_g_o, itlb_ans_u_o};
  assign dtlb_ans = {dtlb_ans_ppn_o, dtlb_ans_page_type_o, dtlb_ans_exception_o,
                     dtlb_ans_wrx_o, dtlb_ans_d_o, dtlb_ans_g_o, dtlb_ans_u_o};

  walk_checker #(.PORT_NAME ("itlb")) itlb_checker (
    .clk_i (clk_i), .rst_ni (rst_ni), .ans_valid_i (itlb_ans_valid_o),
    .ans_rdy_i (itlb_ans_rdy_i), .ans_i (itlb_ans)
  );

  walk_checker #(.PORT_NAME ("dtlb")) dtlb_checker (
    .clk_i (clk_i), .rst_ni (rst_ni), .ans_valid_i (dtlb_ans_valid_o),
    .ans_rdy_i (dtlb_ans_rdy_i), .ans_i (dtlb_ans)
  );

  always #4 clk_i = ~clk_i;

  // Answer ready, random on the DTLB while stalling
  always @(posedge clk_i) begin
    itlb_ans_rdy_i <= 1'b1;
    dtlb_ans_rdy_i <= stall_dtlb ? (($urandom % 2) == 1) : 1'b1;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: walks still open after %0d cycles", CYCLE_LIMIT);
      other_errors = other_errors + 1;
      finish_run();
    end
  end

  function automatic pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
    return {10'h000, ppn, 2'b00, flags};
  endfunction

  // Background PTE built from every address bit
  function automatic pte_t fill_pte(input logic [MEM_AW-1:0] a);
    ppn_t       ppn;
    logic [7:0] flags;
    ppn   = {8'h00, 12'(a * 12'd3), a, a};
    flags = a[7:0] ^ {a[11:8], a[11:8]};
    return make_pte(ppn, flags);
  endfunction

  // Word index of the PTE for one VPN part in one table
  function automatic logic [MEM_AW-1:0] table_word(input ppn_t ppn, input logic [8:0] part);
    paddr_t pa;
    pa = {ppn, part, 3'b000};
    return pa[MEM_AW+2:3];
  endfunction

  // Expected answer from the Sv39 rules applied to the mirror
  function automatic ans_t walk_ref(input vpn_t vpn);
    ppn_t       tbl;
    pte_t       pte;
    int         lvl;
    logic       v, r, w, x;
    logic       is_leaf, misaligned, fault;
    page_type_e ptype;
    exception_e exc;
    tbl = ROOT_PPN;
    for (lvl = 2; lvl >= 0; lvl--) begin
      pte = mirror[table_word(tbl, vpn[lvl*9 +: 9])];
      v = pte[PTE_V_BIT];
      r = pte[PTE_R_BIT];
      w = pte[PTE_W_BIT];
      x = pte[PTE_X_BIT];
      is_leaf = r || x;
      // Superpages need zero lower PPN parts
      misaligned = is_leaf && ((lvl == 2 && pte[27:10] != '0) ||
                               (lvl == 1 && pte[18:10] != '0));
      fault = !v || (w && !r) || (!is_leaf && lvl == 0) || misaligned;
      if (fault || is_leaf) begin
        ptype = (lvl == 2) ? GibiPage : ((lvl == 1) ? MebiPage : KibiPage);
        exc   = fault ? PageFault : NoException;
        return {pte[53:10], ptype, exc, w, r, x, pte[7], pte[5], pte[4]};
      end
      tbl = pte[53:10];
    end
    return '0;
  endfunction

  function automatic vpn_t pick_vpn();
    vpn_t v;
    v = vpn_t'($urandom);
    // Half go under the directed root and mid entries
    if (($urandom % 2) == 1) begin
      v[26:9] = {9'd1, 9'($urandom % 5)};
    end
    return v;
  endfunction

  task automatic write_word(input logic [MEM_AW-1:0] addr, input pte_t data);
    @(posedge clk_i);
    mem_we_i    <= 1'b1;
    mem_waddr_i <= addr;
    mem_wdata_i <= data;
    mirror[addr] = data;
  endtask

  task automatic load_tables();
    for (int a = 0; a < MEM_WORDS; a++) begin
      write_word(MEM_AW'(a), fill_pte(MEM_AW'(a)));
    end
    // Root table
    write_word(table_word(ROOT_PPN, 9'd1), make_pte(MID_PPN, FLAG_V));
    write_word(table_word(ROOT_PPN, 9'd2),
               make_pte(44'h40000, FLAG_V | FLAG_R | FLAG_W | FLAG_X | FLAG_A | FLAG_D));
    write_word(table_word(ROOT_PPN, 9'd3), make_pte(44'h40001, FLAG_V | FLAG_R));
    // Mid table
    write_word(table_word(MID_PPN, 9'd1), make_pte(LEAF_PPN, FLAG_V));
    write_word(table_word(MID_PPN, 9'd3), make_pte(44'h600, FLAG_V | FLAG_R | FLAG_A | FLAG_U));
    write_word(table_word(MID_PPN, 9'd4), make_pte(44'h601, FLAG_V | FLAG_X));
    // Leaf table, two good pages then three faults
    write_word(table_word(LEAF_PPN, 9'd5),
               make_pte(44'h12345, FLAG_V | FLAG_R | FLAG_X | FLAG_U | FLAG_A));
    write_word(table_word(LEAF_PPN, 9'd6),
               make_pte(44'hABCDE, FLAG_V | FLAG_R | FLAG_W | FLAG_G | FLAG_A | FLAG_D));
    write_word(table_word(LEAF_PPN, 9'd7), '0);
    write_word(table_word(LEAF_PPN, 9'd8), make_pte(44'h777, FLAG_V | FLAG_W));
    write_word(table_word(LEAF_PPN, 9'd9), make_pte(44'd4, FLAG_V));
    @(posedge clk_i);
    mem_we_i <= 1'b0;
  endtask

  // Hold the request until accepted, then log its expected answer
  task automatic send_req(input int port, input vpn_t vpn, input string name,
                          input bit answers);
    ans_t exp;
    exp = walk_ref(vpn);
    @(posedge clk_i);
    if (port == 0) begin
      itlb_req_valid_i <= 1'b1;
      itlb_req_vpn_i   <= vpn;
    end else begin
      dtlb_req_valid_i <= 1'b1;
      dtlb_req_vpn_i   <= vpn;
    end
    do begin
      @(posedge clk_i);
    end while (!((port == 0) ? itlb_req_rdy_o : dtlb_req_rdy_o));
    if (port == 0) begin
      itlb_req_valid_i <= 1'b0;
      if (answers) itlb_checker.expect_answer(name, exp);
    end else begin
      dtlb_req_valid_i <= 1'b0;
      if (answers) dtlb_checker.expect_answer(name, exp);
    end
  endtask

  task automatic random_walks(input int port, input int count, input string prefix);
    for (int i = 0; i < count; i++) begin
      send_req(port, pick_vpn(), $sformatf("%s_%0d", prefix, i), 1'b1);
    end
  endtask

  task automatic drain();
    while (itlb_checker.pending() != 0 || dtlb_checker.pending() != 0) begin
      @(posedge clk_i);
    end
    @(posedge clk_i);
  endtask

  task automatic finish_run();
    int total;
    total = other_errors + itlb_checker.error_count + dtlb_checker.error_count;
    $display("Error counts: itlb %0d, dtlb %0d, other %0d, total %0d",
             itlb_checker.error_count, dtlb_checker.error_count, other_errors, total);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  initial begin
    int seed_value;
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    flush_i          = 1'b0;
    csr_root_ppn_i   = ROOT_PPN;
    itlb_req_valid_i = 1'b0;
    dtlb_req_valid_i = 1'b0;
    itlb_req_vpn_i   = '0;
    dtlb_req_vpn_i   = '0;
    itlb_ans_rdy_i   = 1'b1;
    dtlb_ans_rdy_i   = 1'b1;
    mem_we_i         = 1'b0;
    mem_waddr_i      = '0;
    mem_wdata_i      = '0;
    seed_value       = $urandom(SEED);
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    if (!itlb_req_rdy_o || !dtlb_req_rdy_o || itlb_ans_valid_o || dtlb_ans_valid_o) begin
      $display("After reset the walkers were not ready or showed an answer");
      other_errors++;
    end
    load_tables();
    // 4 KiB pages, superpages, then one fault of each kind
    send_req(0, {9'd1, 9'd1, 9'd5}, "kibi_itlb", 1'b1);
    send_req(1, {9'd1, 9'd1, 9'd6}, "kibi_dtlb", 1'b1);
    send_req(0, {9'd2, 9'd5, 9'd7}, "gibi_itlb", 1'b1);
    send_req(1, {9'd1, 9'd3, 9'd20}, "mebi_dtlb", 1'b1);
    send_req(0, {9'd1, 9'd1, 9'd7}, "fault_invalid", 1'b1);
    send_req(1, {9'd1, 9'd1, 9'd8}, "fault_w_no_r", 1'b1);
    send_req(0, {9'd1, 9'd1, 9'd9}, "fault_ptr_last", 1'b1);
    send_req(1, {9'd3, 9'd0, 9'd0}, "fault_misaligned_gibi", 1'b1);
    send_req(0, {9'd1, 9'd4, 9'd2}, "fault_misaligned_mebi", 1'b1);
    drain();
    // Both ports at once, reads interleave
    fork
      random_walks(0, 15, "rand_itlb");
      random_walks(1, 15, "rand_dtlb");
    join
    drain();
    // DTLB back-pressure while the ITLB keeps going
    stall_dtlb <= 1'b1;
    fork
      random_walks(0, 6, "stall_itlb");
      random_walks(1, 6, "stall_dtlb");
    join
    drain();
    stall_dtlb <= 1'b0;
    // Flush mid-walk, then the window where no answer may appear
    send_req(0, {9'd1, 9'd1, 9'd6}, "flushed_walk", 1'b0);
    repeat (3) @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    repeat (16) @(posedge clk_i);
    send_req(0, {9'd1, 9'd1, 9'd5}, "after_flush", 1'b1);
    drain();
    finish_run();
  end

endmodule

/* sim.f */
source/sv39_pkg.sv
source/ptw_pkg.sv
source/pte_checker.sv
source/ptw.sv
source/pt_mem_arbiter.sv
source/pt_memory.sv
source/mmu_walk_top.sv
testbench/walk_checker.sv
testbench/tb_mmu_walk.sv
